// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module tb_dec_stage -f dec_stage.f -o tb_dec_stage
	./obj_dir/tb_dec_stage | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: dec_pkg.sv
`default_nettype none

package dec_pkg;

   //////////////////////////////////////////////////
   // base widths
   //////////////////////////////////////////////////

   // data, pc and instruction word
   typedef logic [31:0] word_t;
   // gpr index
   typedef logic [4:0]  reg_idx_t;

   // opcode class, inst[31:26]
   typedef enum logic [5:0] {
      cls_alu_rr  = 6'd0,
      cls_alu_ri  = 6'd1,
      cls_pcaddi  = 6'd2,
      cls_load    = 6'd3,
      cls_store   = 6'd4,
      cls_branch  = 6'd5,
      cls_bl      = 6'd6,
      cls_mul     = 6'd7,
      cls_syscall = 6'd8,
      cls_break   = 6'd9
   } class_t;

   //////////////////////////////////////////////////
   // unit op codes, all from inst[25:22]
   //////////////////////////////////////////////////

   typedef logic [3:0] alu_op_t;
   typedef logic [3:0] lsu_op_t;
   typedef logic [3:0] bru_op_t;
   typedef logic [3:0] mul_op_t;

   localparam alu_op_t alu_op_add = 4'd0;
   // reserved branch code for bl
   localparam bru_op_t bru_op_bl  = 4'd15;

   // multiply variants, anything else is illegal
   localparam mul_op_t mul_w      = 4'd0;
   localparam mul_op_t mulh_w     = 4'd1;
   localparam mul_op_t mulh_wu    = 4'd2;

   // exception codes
   typedef logic [5:0] exccode_t;
   localparam exccode_t exc_sys = 6'd11;
   localparam exccode_t exc_brk = 6'd12;
   localparam exccode_t exc_ine = 6'd13;

   // bl link target
   localparam reg_idx_t link_reg = 5'd1;

   //////////////////////////////////////////////////
   // records
   //////////////////////////////////////////////////

   typedef struct packed {
      logic     valid;
      exccode_t code;
   } exc_t;

   // decoded control, before dispatch gating
   typedef struct packed {
      logic is_alu;
      logic is_lsu;
      logic is_bru;
      logic is_mul;
      logic b_imm;
      logic a_pc;
      logic rd_read;
      logic rf_wen;
      logic mul_signed;
      logic mul_hi;
      exc_t exc;
   } dec_ctrl_t;

   typedef struct packed {
      word_t    a;
      word_t    b;
      alu_op_t  op;
      logic     b_imm;
      logic     wen;
      reg_idx_t rd;
   } alu_issue_t;

   typedef struct packed {
      logic     valid;
      lsu_op_t  op;
      word_t    imm;
      reg_idx_t rd;
      logic     wen;
   } lsu_issue_t;

   typedef struct packed {
      logic    valid;
      bru_op_t op;
      word_t   offset;
   } bru_issue_t;

   typedef struct packed {
      logic     valid;
      logic     wen;
      logic     signed_op;
      logic     hi;
      reg_idx_t rd;
   } mul_issue_t;

endpackage

`default_nettype wire

// File: dec_stage.f
+incdir+.
dec_pkg.sv
inst_decoder.sv
imm_decoder.sv
issue_ctrl.sv
dec_to_exe_reg.sv
dec_stage.sv
tb_dec_stage.sv

// File: dec_stage.sv
`timescale 1ns/100ps
`default_nettype none

module dec_stage (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire logic                inst_valid,
   input  wire dec_pkg::word_t      inst,
   input  wire dec_pkg::word_t      pc,
   input  wire dec_pkg::word_t      rs1_data,
   input  wire dec_pkg::word_t      rs2_data,
   output      dec_pkg::reg_idx_t   rs1,
   output      dec_pkg::reg_idx_t   rs2,
   output      dec_pkg::reg_idx_t   rs1_e,
   output      dec_pkg::reg_idx_t   rs2_e,
   output      dec_pkg::alu_issue_t alu,
   output      dec_pkg::lsu_issue_t lsu,
   output      dec_pkg::bru_issue_t bru,
   output      dec_pkg::mul_issue_t mul,
   output      dec_pkg::exc_t       exc
);

   //////////////////////////////////////////////////
   // decode side, all combinational
   //////////////////////////////////////////////////

   dec_pkg::dec_ctrl_t  ctrl;
   dec_pkg::word_t      imm;
   dec_pkg::word_t      br_offset;

   // _d records into the stage register
   dec_pkg::alu_issue_t alu_d;
   dec_pkg::lsu_issue_t lsu_d;
   dec_pkg::bru_issue_t bru_d;
   dec_pkg::mul_issue_t mul_d;
   dec_pkg::exc_t       exc_d;

   // class, selects and exception
   inst_decoder i_inst_decoder (
      .inst (inst),
      .ctrl (ctrl)
   );

   // immediates and branch offset
   imm_decoder i_imm_decoder (
      .inst      (inst),
      .imm       (imm),
      .br_offset (br_offset)
   );

   // rs1/rs2 leave here with zero latency
   issue_ctrl i_issue_ctrl (
      .inst       (inst),
      .pc         (pc),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .imm        (imm),
      .br_offset  (br_offset),
      .inst_valid (inst_valid),
      .ctrl       (ctrl),
      .rs1        (rs1),
      .rs2        (rs2),
      .alu_d      (alu_d),
      .lsu_d      (lsu_d),
      .bru_d      (bru_d),
      .mul_d      (mul_d),
      .exc_d      (exc_d)
   );

   // one cycle to _e
   dec_to_exe_reg i_dec_to_exe_reg (
      .clk   (clk),
      .rst_n (rst_n),
      .alu_d (alu_d),
      .lsu_d (lsu_d),
      .bru_d (bru_d),
      .mul_d (mul_d),
      .exc_d (exc_d),
      .rs1_d (rs1),
      .rs2_d (rs2),
      .alu_e (alu),
      .lsu_e (lsu),
      .bru_e (bru),
      .mul_e (mul),
      .exc_e (exc),
      .rs1_e (rs1_e),
      .rs2_e (rs2_e)
   );

endmodule

`default_nettype wire

// File: dec_to_exe_reg.sv
`timescale 1ns/100ps
`default_nettype none

module dec_to_exe_reg (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire dec_pkg::alu_issue_t alu_d,
   input  wire dec_pkg::lsu_issue_t lsu_d,
   input  wire dec_pkg::bru_issue_t bru_d,
   input  wire dec_pkg::mul_issue_t mul_d,
   input  wire dec_pkg::exc_t       exc_d,
   input  wire dec_pkg::reg_idx_t   rs1_d,
   input  wire dec_pkg::reg_idx_t   rs2_d,
   output      dec_pkg::alu_issue_t alu_e,
   output      dec_pkg::lsu_issue_t lsu_e,
   output      dec_pkg::bru_issue_t bru_e,
   output      dec_pkg::mul_issue_t mul_e,
   output      dec_pkg::exc_t       exc_e,
   output      dec_pkg::reg_idx_t   rs1_e,
   output      dec_pkg::reg_idx_t   rs2_e
);

   // payload copies
   dec_pkg::alu_issue_t alu_q;
   dec_pkg::lsu_issue_t lsu_q;
   dec_pkg::bru_issue_t bru_q;
   dec_pkg::mul_issue_t mul_q;
   dec_pkg::exc_t       exc_q;

   // control bits
   logic alu_wen_q;
   logic lsu_valid_q;
   logic lsu_wen_q;
   logic bru_valid_q;
   logic mul_valid_q;
   logic mul_wen_q;
   logic exc_valid_q;

   //////////////////////////////////////////////////
   // control register
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         alu_wen_q   <= 1'b0;
         lsu_valid_q <= 1'b0;
         lsu_wen_q   <= 1'b0;
         bru_valid_q <= 1'b0;
         mul_valid_q <= 1'b0;
         mul_wen_q   <= 1'b0;
         exc_valid_q <= 1'b0;
      end else begin
         alu_wen_q   <= alu_d.wen;
         lsu_valid_q <= lsu_d.valid;
         lsu_wen_q   <= lsu_d.wen;
         bru_valid_q <= bru_d.valid;
         mul_valid_q <= mul_d.valid;
         mul_wen_q   <= mul_d.wen;
         exc_valid_q <= exc_d.valid;
      end
   end

   // data register, loads every cycle
   always_ff @(posedge clk) begin
      alu_q <= alu_d;
      lsu_q <= lsu_d;
      bru_q <= bru_d;
      mul_q <= mul_d;
      exc_q <= exc_d;
      rs1_e <= rs1_d;
      rs2_e <= rs2_d;
   end

   // merge control bits back over the payload
   always_comb begin
      alu_e       = alu_q;
      alu_e.wen   = alu_wen_q;
      lsu_e       = lsu_q;
      lsu_e.valid = lsu_valid_q;
      lsu_e.wen   = lsu_wen_q;
      bru_e       = bru_q;
      bru_e.valid = bru_valid_q;
      mul_e       = mul_q;
      mul_e.valid = mul_valid_q;
      mul_e.wen   = mul_wen_q;
      exc_e       = exc_q;
      exc_e.valid = exc_valid_q;
   end

endmodule

`default_nettype wire

// File: imm_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module imm_decoder (
   input  wire dec_pkg::word_t inst,
   output      dec_pkg::word_t imm,
   output      dec_pkg::word_t br_offset
);

   // candidate immediates
   dec_pkg::word_t imm12;
   dec_pkg::word_t imm20;
   dec_pkg::word_t br_offs;
   dec_pkg::word_t bl_offs;

   logic is_pcaddi;
   logic is_bl;

   assign is_pcaddi = (inst[31:26] == dec_pkg::cls_pcaddi);
   assign is_bl     = (inst[31:26] == dec_pkg::cls_bl);

   //////////////////////////////////////////////////
   // field extraction
   //////////////////////////////////////////////////

   // si12 in [21:10]
   assign imm12   = {{20{inst[21]}}, inst[21:10]};
   // si20 in [24:5], upper part
   assign imm20   = {inst[24:5], 12'd0};
   // branch offs16 is the same field, word aligned
   assign br_offs = {{18{inst[21]}}, inst[21:10], 2'b00};
   // bl offs26 covers [25:0]
   assign bl_offs = {{4{inst[25]}}, inst[25:0], 2'b00};

   // alu b and lsu address immediate
   assign imm       = is_pcaddi ? imm20 : imm12;
   // branch target offset
   assign br_offset = is_bl ? bl_offs : br_offs;

endmodule

`default_nettype wire

// File: inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
   input  wire dec_pkg::word_t     inst,
   output      dec_pkg::dec_ctrl_t ctrl
);

   // opcode class and mul variant fields
   dec_pkg::class_t  cls;
   dec_pkg::mul_op_t mul_op;

   // exception sources
   logic sys_hit;
   logic brk_hit;
   logic ine_hit;
   logic mul_bad;
   logic cls_known;

   assign cls    = dec_pkg::class_t'(inst[31:26]);
   assign mul_op = inst[25:22];

   // only the three word variants exist
   assign mul_bad = (mul_op != dec_pkg::mul_w) &&
                    (mul_op != dec_pkg::mulh_w) &&
                    (mul_op != dec_pkg::mulh_wu);

   // classes 0..9 are defined
   assign cls_known = (inst[31:26] <= 6'd9);

   assign sys_hit = (cls == dec_pkg::cls_syscall);
   assign brk_hit = (cls == dec_pkg::cls_break);
   assign ine_hit = !cls_known || ((cls == dec_pkg::cls_mul) && mul_bad);

   //////////////////////////////////////////////////
   // class flags, operand selects, write enable
   //////////////////////////////////////////////////

   always_comb begin
      ctrl = '0;
      case (cls)
         dec_pkg::cls_alu_rr: begin
            // rj op rk
            ctrl.is_alu = 1'b1;
            ctrl.rf_wen = 1'b1;
         end
         dec_pkg::cls_alu_ri: begin
            // rj op imm12
            ctrl.is_alu = 1'b1;
            ctrl.b_imm  = 1'b1;
            ctrl.rf_wen = 1'b1;
         end
         dec_pkg::cls_pcaddi: begin
            // pc + imm20
            ctrl.is_alu = 1'b1;
            ctrl.a_pc   = 1'b1;
            ctrl.b_imm  = 1'b1;
            ctrl.rf_wen = 1'b1;
         end
         dec_pkg::cls_load: begin
            ctrl.is_lsu = 1'b1;
            ctrl.rf_wen = 1'b1;
         end
         dec_pkg::cls_store: begin
            // store data comes from rd
            ctrl.is_lsu  = 1'b1;
            ctrl.rd_read = 1'b1;
         end
         dec_pkg::cls_branch: begin
            // compare rj with rd
            ctrl.is_bru  = 1'b1;
            ctrl.rd_read = 1'b1;
         end
         dec_pkg::cls_bl: begin
            // writes the link register
            ctrl.is_bru = 1'b1;
            ctrl.rf_wen = 1'b1;
         end
         dec_pkg::cls_mul: begin
            ctrl.is_mul     = 1'b1;
            ctrl.rf_wen     = 1'b1;
            ctrl.mul_signed = (mul_op == dec_pkg::mul_w) || (mul_op == dec_pkg::mulh_w);
            ctrl.mul_hi     = (mul_op == dec_pkg::mulh_w) || (mul_op == dec_pkg::mulh_wu);
         end
         default: begin
            // syscall, break and unknown classes dispatch nowhere
         end
      endcase

      // exception, priority sys > brk > ine
      if (sys_hit) begin
         ctrl.exc.valid = 1'b1;
         ctrl.exc.code  = dec_pkg::exc_sys;
      end else if (brk_hit) begin
         ctrl.exc.valid = 1'b1;
         ctrl.exc.code  = dec_pkg::exc_brk;
      end else if (ine_hit) begin
         ctrl.exc.valid = 1'b1;
         ctrl.exc.code  = dec_pkg::exc_ine;
      end
   end

endmodule

`default_nettype wire

// File: issue_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module issue_ctrl (
   input  wire dec_pkg::word_t     inst,
   input  wire dec_pkg::word_t     pc,
   input  wire dec_pkg::word_t     rs1_data,
   input  wire dec_pkg::word_t     rs2_data,
   input  wire dec_pkg::word_t     imm,
   input  wire dec_pkg::word_t     br_offset,
   input  wire logic               inst_valid,
   input  wire dec_pkg::dec_ctrl_t ctrl,
   output      dec_pkg::reg_idx_t  rs1,
   output      dec_pkg::reg_idx_t  rs2,
   output      dec_pkg::alu_issue_t alu_d,
   output      dec_pkg::lsu_issue_t lsu_d,
   output      dec_pkg::bru_issue_t bru_d,
   output      dec_pkg::mul_issue_t mul_d,
   output      dec_pkg::exc_t      exc_d
);

   //////////////////////////////////////////////////
   // dispatch gating
   //////////////////////////////////////////////////

   // valid and exception free
   logic issue_ok;
   logic alu_dispatch;
   logic lsu_dispatch;
   logic bru_dispatch;
   logic mul_dispatch;

   logic              alu_b_imm;
   logic              is_pcaddi;
   logic              is_bl;
   dec_pkg::reg_idx_t rf_target;

   assign issue_ok     = inst_valid && !ctrl.exc.valid;
   assign alu_dispatch = ctrl.is_alu && issue_ok;
   assign lsu_dispatch = ctrl.is_lsu && issue_ok;
   assign bru_dispatch = ctrl.is_bru && issue_ok;
   assign mul_dispatch = ctrl.is_mul && issue_ok;

   assign is_pcaddi = (inst[31:26] == dec_pkg::cls_pcaddi);
   assign is_bl     = (inst[31:26] == dec_pkg::cls_bl);

   // register read ports, rj always on port 1
   assign rs1 = inst[9:5];
   // rd on port 2 for store data and branch compare
   assign rs2 = ctrl.rd_read ? inst[4:0] : inst[14:10];

   // bl links into r1
   assign rf_target = is_bl ? dec_pkg::link_reg : inst[4:0];

   //////////////////////////////////////////////////
   // per unit records
   //////////////////////////////////////////////////

   // imm select only when the alu actually takes it
   assign alu_b_imm = ctrl.b_imm && alu_dispatch;

   // alu
   assign alu_d.a     = ctrl.a_pc ? pc : rs1_data;
   assign alu_d.b     = alu_b_imm ? imm : rs2_data;
   assign alu_d.op    = is_pcaddi ? dec_pkg::alu_op_add : inst[25:22];
   assign alu_d.b_imm = alu_b_imm;
   assign alu_d.wen   = ctrl.rf_wen && alu_dispatch;
   assign alu_d.rd    = rf_target;

   // lsu, address is rj + imm12
   assign lsu_d.valid = lsu_dispatch;
   assign lsu_d.op    = inst[25:22];
   assign lsu_d.imm   = imm;
   assign lsu_d.rd    = rf_target;
   assign lsu_d.wen   = ctrl.rf_wen && lsu_dispatch;

   // bru
   assign bru_d.valid  = bru_dispatch;
   assign bru_d.op     = is_bl ? dec_pkg::bru_op_bl : inst[25:22];
   assign bru_d.offset = br_offset;

   // mul
   assign mul_d.valid     = mul_dispatch;
   assign mul_d.wen       = ctrl.rf_wen && mul_dispatch;
   assign mul_d.signed_op = ctrl.mul_signed;
   assign mul_d.hi        = ctrl.mul_hi;
   assign mul_d.rd        = rf_target;

   // exception leaves only with a valid instruction
   assign exc_d.valid = ctrl.exc.valid && inst_valid;
   assign exc_d.code  = ctrl.exc.code;

endmodule

`default_nettype wire

// File: tb_dec_model.svh
// expected dut outputs for one instruction
typedef struct packed {
   dec_pkg::alu_issue_t alu;
   dec_pkg::lsu_issue_t lsu;
   dec_pkg::bru_issue_t bru;
   dec_pkg::mul_issue_t mul;
   dec_pkg::exc_t       exc;
   dec_pkg::reg_idx_t   rs1;
   dec_pkg::reg_idx_t   rs2;
} expect_t;

// xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] s);
   logic [31:0] x;
   x = s;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

// random instruction word, mostly known classes
function automatic dec_pkg::word_t build_inst(input logic [31:0] r_cls,
                                              input logic [31:0] r_body);
   logic [5:0]     cls;
   dec_pkg::word_t w;
   if (r_cls[31:29] == 3'd0) begin
      // roughly one in eight lands on an undefined class
      cls = 6'd10 + (r_cls[13:8] % 6'd54);
   end else begin
      cls = 6'(r_cls[7:0] % 8'd10);
   end
   w = {cls, r_body[25:0]};
   // mul variants 0..3 most of the time, 3 is illegal
   if ((cls == dec_pkg::cls_mul) && (r_cls[17:16] != 2'd0)) begin
      w[25:22] = {2'b00, r_cls[19:18]};
   end
   return w;
endfunction

//////////////////////////////////////////////////
// reference decode
//////////////////////////////////////////////////

function automatic expect_t decode_model(input dec_pkg::word_t inst,
                                         input dec_pkg::word_t pc,
                                         input logic           valid,
                                         input dec_pkg::word_t d1,
                                         input dec_pkg::word_t d2);
   expect_t           e;
   logic [5:0]        cls;
   logic [3:0]        op;
   logic              alu_cls;
   logic              lsu_cls;
   logic              bru_cls;
   logic              mul_cls;
   logic              is_pcaddi;
   logic              is_bl;
   logic              exc_hit;
   logic              go;
   logic              use_imm;
   dec_pkg::exccode_t code;
   dec_pkg::word_t    imm;
   dec_pkg::word_t    offset;
   dec_pkg::reg_idx_t rd;

   cls       = inst[31:26];
   op        = inst[25:22];
   alu_cls   = (cls <= 6'd2);
   lsu_cls   = (cls == dec_pkg::cls_load) || (cls == dec_pkg::cls_store);
   bru_cls   = (cls == dec_pkg::cls_branch) || (cls == dec_pkg::cls_bl);
   mul_cls   = (cls == dec_pkg::cls_mul);
   is_pcaddi = (cls == dec_pkg::cls_pcaddi);
   is_bl     = (cls == dec_pkg::cls_bl);

   // syscall wins over break, break over illegal
   exc_hit = 1'b1;
   if (cls == dec_pkg::cls_syscall) begin
      code = dec_pkg::exc_sys;
   end else if (cls == dec_pkg::cls_break) begin
      code = dec_pkg::exc_brk;
   end else if ((cls > 6'd9) || (mul_cls && (op > 4'd2))) begin
      code = dec_pkg::exc_ine;
   end else begin
      exc_hit = 1'b0;
      code    = '0;
   end
   go = valid && !exc_hit;

   // immediate and offset extraction
   if (is_pcaddi) begin
      imm = {inst[24:5], 12'h000};
   end else begin
      imm = 32'($signed(inst[21:10]));
   end
   if (is_bl) begin
      offset = 32'($signed(inst[25:0])) << 2;
   end else begin
      offset = 32'($signed(inst[21:10])) << 2;
   end
   rd      = is_bl ? dec_pkg::link_reg : inst[4:0];
   use_imm = alu_cls && (cls != dec_pkg::cls_alu_rr) && go;

   e.alu.a         = is_pcaddi ? pc : d1;
   e.alu.b         = use_imm ? imm : d2;
   e.alu.op        = is_pcaddi ? dec_pkg::alu_op_add : op;
   e.alu.b_imm     = use_imm;
   e.alu.wen       = alu_cls && go;
   e.alu.rd        = rd;
   e.lsu.valid     = lsu_cls && go;
   e.lsu.op        = op;
   e.lsu.imm       = imm;
   e.lsu.rd        = rd;
   e.lsu.wen       = (cls == dec_pkg::cls_load) && go;
   e.bru.valid     = bru_cls && go;
   e.bru.op        = is_bl ? dec_pkg::bru_op_bl : op;
   e.bru.offset    = offset;
   e.mul.valid     = mul_cls && go;
   e.mul.wen       = mul_cls && go;
   e.mul.signed_op = mul_cls && ((op == dec_pkg::mul_w) || (op == dec_pkg::mulh_w));
   e.mul.hi        = mul_cls && ((op == dec_pkg::mulh_w) || (op == dec_pkg::mulh_wu));
   e.mul.rd        = rd;
   e.exc.valid     = exc_hit && valid;
   e.exc.code      = code;
   // store and branch read rd on port 2
   e.rs1 = inst[9:5];
   e.rs2 = ((cls == dec_pkg::cls_store) || (cls == dec_pkg::cls_branch)) ?
           inst[4:0] : inst[14:10];
   return e;
endfunction

// File: tb_dec_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dec_stage;

   `include "tb_dec_model.svh"

   localparam int num_inst   = 2000;
   localparam int clk_period = 20;

   logic                clk = 1'b0;
   logic                rst_n;
   logic                inst_valid;
   dec_pkg::word_t      inst;
   dec_pkg::word_t      pc;
   dec_pkg::word_t      rs1_data;
   dec_pkg::word_t      rs2_data;
   dec_pkg::reg_idx_t   rs1;
   dec_pkg::reg_idx_t   rs2;
   dec_pkg::reg_idx_t   rs1_e;
   dec_pkg::reg_idx_t   rs2_e;
   dec_pkg::alu_issue_t alu;
   dec_pkg::lsu_issue_t lsu;
   dec_pkg::bru_issue_t bru;
   dec_pkg::mul_issue_t mul;
   dec_pkg::exc_t       exc;

   // generator state and the pending expectation
   logic [31:0] rng;
   expect_t     exp_q;

   always #(clk_period / 2) clk = ~clk;

   dec_stage i_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .inst_valid (inst_valid),
      .inst       (inst),
      .pc         (pc),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .rs1        (rs1),
      .rs2        (rs2),
      .rs1_e      (rs1_e),
      .rs2_e      (rs2_e),
      .alu        (alu),
      .lsu        (lsu),
      .bru        (bru),
      .mul        (mul),
      .exc        (exc)
   );

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   task automatic next_rand(output logic [31:0] r);
      rng = xorshift(rng);
      r   = rng;
   endtask

   task automatic report_mismatch(input string what, input logic [127:0] got,
                                  input logic [127:0] want);
      $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, want);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   // only the reset control bits are defined here
   task automatic check_reset_state();
      logic [6:0] ctl;
      ctl = {alu.wen, lsu.valid, lsu.wen, bru.valid, mul.valid, mul.wen, exc.valid};
      assert (ctl === 7'b0)
         else report_mismatch("control bits after reset", 128'(ctl), 128'd0);
   endtask

   // one new instruction, valid about 80 percent of the time
   task automatic drive_random();
      logic [31:0] r_cls;
      logic [31:0] r_body;
      logic [31:0] r_ctl;
      next_rand(r_cls);
      next_rand(r_body);
      next_rand(r_ctl);
      inst       = build_inst(r_cls, r_body);
      inst_valid = (r_ctl % 32'd5) != 32'd0;
      next_rand(pc);
      next_rand(rs1_data);
      next_rand(rs2_data);
      exp_q = decode_model(inst, pc, inst_valid, rs1_data, rs2_data);
   endtask

   // _e outputs after the edge, rs1/rs2 still from the same inst
   task automatic check_outputs(input expect_t e);
      assert (alu === e.alu)
         else report_mismatch("alu", 128'(alu), 128'(e.alu));
      assert (lsu === e.lsu)
         else report_mismatch("lsu", 128'(lsu), 128'(e.lsu));
      assert (bru === e.bru)
         else report_mismatch("bru", 128'(bru), 128'(e.bru));
      assert (mul === e.mul)
         else report_mismatch("mul", 128'(mul), 128'(e.mul));
      assert (exc === e.exc)
         else report_mismatch("exc", 128'(exc), 128'(e.exc));
      assert (rs1 === e.rs1)
         else report_mismatch("rs1", 128'(rs1), 128'(e.rs1));
      assert (rs2 === e.rs2)
         else report_mismatch("rs2", 128'(rs2), 128'(e.rs2));
      assert (rs1_e === e.rs1)
         else report_mismatch("rs1_e", 128'(rs1_e), 128'(e.rs1));
      assert (rs2_e === e.rs2)
         else report_mismatch("rs2_e", 128'(rs2_e), 128'(e.rs2));
   endtask

   //////////////////////////////////////////////////
   // stimulus and checks
   //////////////////////////////////////////////////

   initial begin
      rng        = 32'hc41;
      rst_n      = 1'b0;
      inst_valid = 1'b0;
      inst       = '0;
      pc         = '0;
      rs1_data   = '0;
      rs2_data   = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_reset_state();
      // drive on the falling edge, check on the next one
      for (int n = 0; n < num_inst; n++) begin
         drive_random();
         @(negedge clk);
         check_outputs(exp_q);
      end
      $display("Simulation PASSED");
      $finish;
   end

   // twice the nominal run length
   initial begin
      #(num_inst * clk_period * 2);
      $display("timeout: run did not finish within %0d ns", num_inst * clk_period * 2);
      $display("Simulation FAILED");
      $fatal(1);
   end

endmodule

`default_nettype wire
